// File: iq_cfg_pkg.sv
//////////////////////////////////////////////////////////////////////
// Instruction queue configuration
// Line geometry, head pointer counts and the slot payload record
//////////////////////////////////////////////////////////////////////

package iq_cfg_pkg;

   // Byte address width of the fetch stream
   localparam int ADDR_W = 32;

   // Line and beat geometry
   localparam int LINE_BYTES = 16;
   localparam int BEAT_BYTES = 8;
   localparam int LINE_OFF_W = $clog2(LINE_BYTES);
   localparam int BEAT_OFF_W = $clog2(BEAT_BYTES);

   // One instruction line, byte 0 in bits 7:0
   typedef logic [LINE_BYTES*8-1:0] line_data_t;

   // Payload of one queue slot
   typedef struct packed {
      line_data_t        data;
      logic              fault;
      logic [ADDR_W-1:0] line_addr;
   } slot_line_t;

   // Queued bytes visible to the decoder, 0 to 64
   typedef logic [6:0] byte_cnt_t;

   // Bytes consumed by the decoder in one cycle, 0 to 16
   typedef logic [4:0] read_cnt_t;

endpackage

// File: axil_pkg.sv
//////////////////////////////////////////////////////////////////////
// AXI4-Lite read channel definitions
// Address and data channel payloads plus response codes
//////////////////////////////////////////////////////////////////////

package axil_pkg;

   localparam int AXIL_ADDR_W = 32;
   localparam int AXIL_DATA_W = 64;

   // Read response codes
   localparam logic [1:0] RESP_OKAY   = 2'b00;
   localparam logic [1:0] RESP_SLVERR = 2'b10;

   // Unprivileged, secure, instruction access
   localparam logic [2:0] ARPROT_INSN = 3'b100;

   // Read address channel payload
   typedef struct packed {
      logic [AXIL_ADDR_W-1:0] araddr;
      logic [2:0]             arprot;
   } axil_ar_t;

   // Read data channel payload
   typedef struct packed {
      logic [AXIL_DATA_W-1:0] rdata;
      logic [1:0]             rresp;
   } axil_r_t;

endpackage

// File: iq_fetch_master.sv
//////////////////////////////////////////////////////////////////////
// Instruction fetch master
// Reads sequential lines as two AXI4-Lite beats each and fills the
// tail slot of the queue once both halves have returned
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module iq_fetch_master #(
   parameter int NUM_SLOTS = 4
) (
   input  logic                            clk,
   input  logic                            rst_i,
   input  logic                            redirect_valid_i,
   input  logic [iq_cfg_pkg::ADDR_W-1:0]   redirect_addr_i,
   input  logic [$clog2(NUM_SLOTS):0]      free_cnt_i,
   output logic                            arvalid_o,
   input  logic                            arready_i,
   output axil_pkg::axil_ar_t              ar_o,
   input  logic                            rvalid_i,
   output logic                            rready_o,
   input  axil_pkg::axil_r_t               r_i,
   output logic                            fill_valid_o,
   output logic [$clog2(NUM_SLOTS)-1:0]    fill_idx_o,
   output iq_cfg_pkg::slot_line_t          fill_line_o
);
   import iq_cfg_pkg::*;
   import axil_pkg::*;

   localparam int IDX_W = $clog2(NUM_SLOTS);

   typedef enum logic [1:0] {
      ST_OFF,
      ST_IDLE,
      ST_ADDR,
      ST_DATA
   } fetch_state_e;

   fetch_state_e           state_q;
   logic                   beat_q;
   logic                   discard_q;
   logic [IDX_W-1:0]       tail_q;
   logic [ADDR_W-1:0]      next_addr_q;
   logic [ADDR_W-1:0]      req_addr_q;
   logic [AXIL_DATA_W-1:0] data_lo_q;
   logic                   fault_lo_q;
   logic [ADDR_W-1:0]      redir_line;
   logic                   r_hs;

   assign redir_line = {redirect_addr_i[ADDR_W-1:LINE_OFF_W], {LINE_OFF_W{1'b0}}};

   // Address channel, second beat sits 8 bytes into the line
   assign arvalid_o   = (state_q == ST_ADDR);
   assign ar_o.araddr = {req_addr_q[ADDR_W-1:LINE_OFF_W], beat_q, {BEAT_OFF_W{1'b0}}};
   assign ar_o.arprot = ARPROT_INSN;

   assign rready_o = (state_q == ST_DATA);
   assign r_hs     = rvalid_i & rready_o;

   // Line is complete on the second beat of a read that is kept
   assign fill_valid_o          = r_hs & beat_q & ~discard_q;
   assign fill_idx_o            = tail_q;
   assign fill_line_o.data      = {r_i.rdata, data_lo_q};
   assign fill_line_o.fault     = fault_lo_q | (r_i.rresp != RESP_OKAY);
   assign fill_line_o.line_addr = req_addr_q;

   always_ff @(posedge clk) begin
      if (rst_i) begin
         state_q     <= ST_OFF;
         beat_q      <= 1'b0;
         discard_q   <= 1'b0;
         tail_q      <= '0;
         next_addr_q <= '0;
         req_addr_q  <= '0;
      end else begin
         unique case (state_q)
            ST_OFF, ST_IDLE: begin
               if (redirect_valid_i) begin
                  req_addr_q <= redir_line;
                  beat_q     <= 1'b0;
                  state_q    <= ST_ADDR;
               end else if (state_q == ST_IDLE && free_cnt_i != '0) begin
                  req_addr_q <= next_addr_q;
                  beat_q     <= 1'b0;
                  state_q    <= ST_ADDR;
               end
            end
            ST_ADDR: begin
               // Address already presented, it has to complete
               if (redirect_valid_i) begin
                  discard_q <= 1'b1;
               end
               if (arready_i) begin
                  state_q <= ST_DATA;
               end
            end
            ST_DATA: begin
               if (r_hs) begin
                  if (discard_q || redirect_valid_i) begin
                     // Stale stream ends here, restart at the newest target
                     discard_q  <= 1'b0;
                     beat_q     <= 1'b0;
                     req_addr_q <= redirect_valid_i ? redir_line : next_addr_q;
                     state_q    <= ST_ADDR;
                  end else if (!beat_q) begin
                     beat_q  <= 1'b1;
                     state_q <= ST_ADDR;
                  end else begin
                     beat_q  <= 1'b0;
                     state_q <= ST_IDLE;
                  end
               end else if (redirect_valid_i) begin
                  discard_q <= 1'b1;
               end
            end
            default: state_q <= ST_OFF;
         endcase

         if (redirect_valid_i) begin
            next_addr_q <= redir_line;
         end else if (fill_valid_o) begin
            next_addr_q <= req_addr_q + ADDR_W'(LINE_BYTES);
         end

         // Slots are flushed on a redirect, so filling restarts at slot 0
         if (redirect_valid_i) begin
            tail_q <= '0;
         end else if (fill_valid_o) begin
            tail_q <= tail_q + 1'b1;
         end
      end
   end

   // Low half of the line waits here for the second beat
   always_ff @(posedge clk) begin
      if (r_hs && !beat_q) begin
         data_lo_q  <= r_i.rdata;
         fault_lo_q <= (r_i.rresp != RESP_OKAY);
      end
   end

endmodule

// File: iq_line_slot.sv
//////////////////////////////////////////////////////////////////////
// Instruction queue slot
// Holds one fetched line with its fault flag until drained or flushed
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module iq_line_slot (
   input  logic                   clk,
   input  logic                   rst_i,
   input  logic                   fill_i,
   input  logic                   drain_i,
   input  logic                   flush_i,
   input  iq_cfg_pkg::slot_line_t line_i,
   output logic                   valid_o,
   output iq_cfg_pkg::slot_line_t line_o
);
   import iq_cfg_pkg::*;

   logic       valid_q;
   slot_line_t line_q;

   // Flush wins over a fill landing on the same edge
   always_ff @(posedge clk) begin
      if (rst_i) begin
         valid_q <= 1'b0;
      end else if (flush_i) begin
         valid_q <= 1'b0;
      end else if (fill_i) begin
         valid_q <= 1'b1;
      end else if (drain_i) begin
         valid_q <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (fill_i) begin
         line_q <= line_i;
      end
   end

   assign valid_o = valid_q;
   assign line_o  = line_q;

endmodule

// File: iq_byte_window.sv
//////////////////////////////////////////////////////////////////////
// Instruction byte window
// Tracks the head slot and byte offset, presents 16 bytes from the
// head onwards and frees slots as the decoder consumes them
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module iq_byte_window #(
   parameter int NUM_SLOTS = 4
) (
   input  logic                                     clk,
   input  logic                                     rst_i,
   input  logic                                     redirect_valid_i,
   input  logic [iq_cfg_pkg::ADDR_W-1:0]            redirect_addr_i,
   input  logic [NUM_SLOTS-1:0]                     slot_valid_i,
   input  iq_cfg_pkg::slot_line_t [NUM_SLOTS-1:0]   slot_line_i,
   input  logic                                     ready_i,
   input  iq_cfg_pkg::read_cnt_t                    bytes_read_i,
   output logic                                     valid_o,
   output iq_cfg_pkg::line_data_t                   window_o,
   output iq_cfg_pkg::byte_cnt_t                    valid_bytes_o,
   output logic                                     fault_o,
   output logic                                     drain_valid_o,
   output logic [$clog2(NUM_SLOTS)-1:0]             drain_idx_o,
   output logic                                     flush_o,
   output logic [$clog2(NUM_SLOTS):0]               free_cnt_o
);
   import iq_cfg_pkg::*;

   localparam int IDX_W = $clog2(NUM_SLOTS);

   logic [IDX_W-1:0]        head_idx_q;
   logic [LINE_OFF_W-1:0]   head_off_q;
   logic [IDX_W-1:0]        next_idx;
   logic                    consume;
   logic [LINE_OFF_W:0]     off_sum;
   slot_line_t              head_line;
   slot_line_t              next_line;
   logic                    next_valid;
   logic [2*LINE_BYTES*8-1:0] line_pair;
   logic [2*LINE_BYTES*8-1:0] pair_shifted;
   logic                    run;
   byte_cnt_t               avail;

   assign consume = valid_o & ready_i;

   // Carry out of the offset means the head line is used up
   assign off_sum = {1'b0, head_off_q} + bytes_read_i;

   always_ff @(posedge clk) begin
      if (rst_i) begin
         head_idx_q <= '0;
         head_off_q <= '0;
      end else if (redirect_valid_i) begin
         head_idx_q <= '0;
         head_off_q <= redirect_addr_i[LINE_OFF_W-1:0];
      end else if (consume) begin
         head_off_q <= off_sum[LINE_OFF_W-1:0];
         if (off_sum[LINE_OFF_W]) begin
            head_idx_q <= head_idx_q + 1'b1;
         end
      end
   end

   assign drain_valid_o = consume & off_sum[LINE_OFF_W];
   assign drain_idx_o   = head_idx_q;
   assign flush_o       = redirect_valid_i;

   // Head and following slot, wrapping around the ring
   assign next_idx   = head_idx_q + 1'b1;
   assign head_line  = slot_line_i[head_idx_q];
   assign next_line  = slot_line_i[next_idx];
   assign next_valid = slot_valid_i[next_idx];

   assign valid_o = slot_valid_i[head_idx_q];

   // Byte shifter over the two lines
   assign line_pair    = {next_line.data, head_line.data};
   assign pair_shifted = line_pair >> {head_off_q, 3'b000};
   assign window_o     = pair_shifted[LINE_BYTES*8-1:0];

   // Bytes held in the run of valid slots starting at the head
   always_comb begin
      run   = 1'b1;
      avail = '0;
      for (int k = 0; k < NUM_SLOTS; k++) begin
         run = run & slot_valid_i[head_idx_q + IDX_W'(k)];
         if (run) begin
            avail = avail + byte_cnt_t'(LINE_BYTES);
         end
      end
   end

   assign valid_bytes_o = valid_o ? (avail - byte_cnt_t'(head_off_q)) : '0;

   // Next line only matters once the window straddles into it
   assign fault_o = valid_o &
                    (head_line.fault |
                     (next_valid & next_line.fault & (head_off_q != '0)));

   // Empty slots, the fetch master keeps one of them for its line in flight
   always_comb begin
      free_cnt_o = '0;
      for (int k = 0; k < NUM_SLOTS; k++) begin
         free_cnt_o = free_cnt_o + (IDX_W+1)'(~slot_valid_i[k]);
      end
   end

endmodule

// File: instruction_queue_top.sv
//////////////////////////////////////////////////////////////////////
// Instruction queue
// Fetch master, ring of line slots and byte window for the decoder
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module instruction_queue_top #(
   parameter int NUM_SLOTS = 4
) (
   input  logic                          clk,
   input  logic                          rst_i,
   input  logic                          redirect_valid_i,
   input  logic [iq_cfg_pkg::ADDR_W-1:0] redirect_addr_i,
   output logic                          arvalid_o,
   input  logic                          arready_i,
   output axil_pkg::axil_ar_t            ar_o,
   input  logic                          rvalid_i,
   output logic                          rready_o,
   input  axil_pkg::axil_r_t             r_i,
   output logic                          valid_o,
   input  logic                          ready_i,
   input  iq_cfg_pkg::read_cnt_t         bytes_read_i,
   output iq_cfg_pkg::line_data_t        window_o,
   output iq_cfg_pkg::byte_cnt_t         valid_bytes_o,
   output logic                          fault_o
);
   import iq_cfg_pkg::*;

   localparam int IDX_W = $clog2(NUM_SLOTS);

   logic                          fill_valid;
   logic [IDX_W-1:0]              fill_idx;
   slot_line_t                    fill_line;
   logic                          drain_valid;
   logic [IDX_W-1:0]              drain_idx;
   logic                          flush;
   logic [IDX_W:0]                free_cnt;
   logic [NUM_SLOTS-1:0]          fill_strb;
   logic [NUM_SLOTS-1:0]          drain_strb;
   logic [NUM_SLOTS-1:0]          slot_valid;
   slot_line_t [NUM_SLOTS-1:0]    slot_line;

   iq_fetch_master #(.NUM_SLOTS(NUM_SLOTS)) u_fetch (
      .clk, .rst_i, .redirect_valid_i, .redirect_addr_i,
      .free_cnt_i(free_cnt),
      .arvalid_o, .arready_i, .ar_o, .rvalid_i, .rready_o, .r_i,
      .fill_valid_o(fill_valid), .fill_idx_o(fill_idx), .fill_line_o(fill_line)
   );

   // Slot index is the generate position
   for (genvar i = 0; i < NUM_SLOTS; i++) begin : g_slot
      assign fill_strb[i]  = fill_valid & (fill_idx == IDX_W'(i));
      assign drain_strb[i] = drain_valid & (drain_idx == IDX_W'(i));

      iq_line_slot u_slot (
         .clk, .rst_i,
         .fill_i(fill_strb[i]), .drain_i(drain_strb[i]), .flush_i(flush),
         .line_i(fill_line), .valid_o(slot_valid[i]), .line_o(slot_line[i])
      );
   end

   iq_byte_window #(.NUM_SLOTS(NUM_SLOTS)) u_window (
      .clk, .rst_i, .redirect_valid_i, .redirect_addr_i,
      .slot_valid_i(slot_valid), .slot_line_i(slot_line),
      .ready_i, .bytes_read_i, .valid_o, .window_o, .valid_bytes_o, .fault_o,
      .drain_valid_o(drain_valid), .drain_idx_o(drain_idx),
      .flush_o(flush), .free_cnt_o(free_cnt)
   );

endmodule

// File: iq_assert.sv
//////////////////////////////////////////////////////////////////////
// Instruction queue assertions
// AXI4-Lite read handshake rules and slot ring occupancy
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module iq_assert #(
   parameter int NUM_SLOTS = 4
) (
   input logic                         clk,
   input logic                         rst_i,
   input logic                         arvalid_i,
   input logic                         arready_i,
   input axil_pkg::axil_ar_t           ar_i,
   input logic                         rvalid_i,
   input logic                         rready_i,
   input logic                         fill_valid_i,
   input logic                         flush_i,
   input logic [$clog2(NUM_SLOTS)-1:0] fill_idx_i,
   input logic [NUM_SLOTS-1:0]         slot_valid_i
);

   // Open from the accepted address until its data beat returns
   logic read_open_q;

   always_ff @(posedge clk) begin
      if (rst_i) begin
         read_open_q <= 1'b0;
      end else if (arvalid_i && arready_i) begin
         read_open_q <= 1'b1;
      end else if (rvalid_i && rready_i) begin
         read_open_q <= 1'b0;
      end
   end

   // Address held until accepted
   ar_stable: assert property (@(posedge clk) disable iff (rst_i)
      arvalid_i && !arready_i |=> arvalid_i && $stable(ar_i))
      else $error("ar_o changed or arvalid_o dropped before arready_i");

   // Only one read in flight, and its data is always accepted
   one_read: assert property (@(posedge clk) disable iff (rst_i)
      read_open_q |-> !arvalid_i && rready_i)
      else $error("address issued or rready_o low while a read is outstanding");

   // A fill never lands on a slot that still holds a line
   fill_empty: assert property (@(posedge clk) disable iff (rst_i)
      fill_valid_i && !flush_i |-> !slot_valid_i[fill_idx_i])
      else $error("fill into an occupied slot");

endmodule

bind instruction_queue_top iq_assert #(.NUM_SLOTS(NUM_SLOTS)) u_iq_assert (
   .clk(clk), .rst_i(rst_i), .arvalid_i(arvalid_o), .arready_i(arready_i), .ar_i(ar_o),
   .rvalid_i(rvalid_i), .rready_i(rready_o), .fill_valid_i(fill_valid), .flush_i(flush),
   .fill_idx_i(fill_idx), .slot_valid_i(slot_valid)
);

// File: tb_instruction_queue.sv
//////////////////////////////////////////////////////////////////////
// Instruction queue testbench
// AXI4-Lite memory with random latency, decoder stimulus and a
// reference model of the byte stream
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_instruction_queue;
   import iq_cfg_pkg::*;
   import axil_pkg::*;

   localparam logic [31:0] ERR_LINE = 32'h0000_5020;

   logic clk, rst_i, redirect_valid_i, arvalid_o, arready_i, rvalid_i, rready_o;
   logic valid_o, ready_i, fault_o;
   logic [31:0] redirect_addr_i;
   axil_ar_t    ar_o;
   axil_r_t     r_i;
   read_cnt_t   bytes_read_i;
   line_data_t  window_o;
   byte_cnt_t   valid_bytes_o;

   logic [15:0] mem_lfsr, stim_lfsr;
   logic [31:0] exp_addr, rd_addr;
   logic        r_pending;
   int          ar_wait, r_wait, consumes, fault_seen;

   instruction_queue_top #(.NUM_SLOTS(4)) u_instruction_queue_top (.*);

   initial clk = 1'b0;
   always #2 clk = ~clk;

   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
   endfunction

   // One LFSR step per bit taken
   task automatic take_bits(ref logic [15:0] s, input int n, output int v);
      v = 0;
      for (int i = 0; i < n; i++) begin
         s = lfsr_next(s);
         v = (v << 1) | int'(s[0]);
      end
   endtask

   function automatic logic [7:0] mem_byte(input logic [31:0] a);
      logic [31:0] p;
      p = a * 32'd37 + 32'd11;
      return p[7:0];
   endfunction

   function automatic logic line_faults(input logic [31:0] a);
      return {a[31:4], 4'h0} == ERR_LINE;
   endfunction

   function automatic line_data_t expected_window(input logic [31:0] a);
      line_data_t w;
      for (int i = 0; i < 16; i++) begin
         w[i*8 +: 8] = mem_byte(a + 32'(i));
      end
      return w;
   endfunction

   task automatic stop_with_failure();
      $display("CHECKS FAILED");
      $fatal(1, "Stopped at the first failing check");
   endtask

   task automatic check_hex(input string name, input logic [127:0] got, input logic [127:0] exp);
      assert (got == exp) else begin
         $display("ERROR %s: got %h expected %h", name, got, exp);
         stop_with_failure();
      end
   endtask

   task automatic check_cond(input logic ok, input string what);
      assert (ok) else begin
         $display("%s", what);
         stop_with_failure();
      end
   endtask

   // Memory model, one read at a time with random AR and R delays
   initial begin
      arready_i = 1'b0;
      rvalid_i  = 1'b0;
      r_i       = '0;
      r_pending = 1'b0;
      ar_wait   = -1;
      r_wait    = 0;
      rd_addr   = '0;
      mem_lfsr  = 16'd22;
      forever begin
         @(negedge clk);
         if (arready_i) begin
            arready_i = 1'b0;
            r_pending = 1'b1;
            take_bits(mem_lfsr, 2, r_wait);
         end else if (arvalid_o && !r_pending) begin
            if (ar_wait < 0) take_bits(mem_lfsr, 2, ar_wait);
            if (ar_wait == 0) begin
               // Fetches are unprivileged, secure instruction accesses
               check_hex("ar_o.arprot", 128'(ar_o.arprot), 128'(3'b100));
               arready_i = 1'b1;
               rd_addr   = ar_o.araddr;
               ar_wait   = -1;
            end else begin
               ar_wait--;
            end
         end
         if (rvalid_i) begin
            rvalid_i  = 1'b0;
            r_pending = 1'b0;
         end else if (r_pending) begin
            if (r_wait == 0) begin
               rvalid_i = 1'b1;
               for (int i = 0; i < 8; i++) r_i.rdata[i*8 +: 8] = mem_byte(rd_addr + 32'(i));
               r_i.rresp = line_faults(rd_addr) ? RESP_SLVERR : RESP_OKAY;
            end else begin
               r_wait--;
            end
         end
      end
   end

   // Compare every consume against the reference stream
   always @(posedge clk) begin
      int          n, off;
      logic [127:0] mask;
      logic        exp_fault;
      if (rst_i) begin
         exp_addr = '0;
      end else if (redirect_valid_i) begin
         exp_addr = redirect_addr_i;
      end else if (valid_o && ready_i) begin
         off  = int'(exp_addr[3:0]);
         n    = (valid_bytes_o > 16) ? 16 : int'(valid_bytes_o);
         mask = '0;
         for (int i = 0; i < n; i++) mask[i*8 +: 8] = 8'hFF;
         check_hex("window_o", window_o & mask, expected_window(exp_addr) & mask);
         check_cond(int'(valid_bytes_o) >= 16 - off && int'(valid_bytes_o) <= 64 - off &&
                    (int'(valid_bytes_o) + off) % 16 == 0,
                    "valid_bytes_o does not match whole lines after the head offset");
         exp_fault = line_faults(exp_addr) ||
                     (off != 0 && int'(valid_bytes_o) > 16 - off && line_faults(exp_addr + 32'd16));
         check_hex("fault_o", 128'(fault_o), 128'(exp_fault));
         if (fault_o) fault_seen++;
         exp_addr = exp_addr + 32'(bytes_read_i);
         consumes++;
      end
   end

   task automatic do_redirect(input logic [31:0] addr);
      ready_i          = 1'b0;
      redirect_valid_i = 1'b1;
      redirect_addr_i  = addr;
      @(negedge clk);
      redirect_valid_i = 1'b0;
   endtask

   task automatic wait_for_valid(input int max);
      int cyc;
      cyc     = 0;
      ready_i = 1'b0;
      while (!valid_o) begin
         if (cyc >= max) check_cond(1'b0, "Timed out waiting for valid_o");
         @(negedge clk);
         cyc++;
      end
   endtask

   task automatic drive_random_consume();
      int r, len, lim;
      take_bits(stim_lfsr, 2, r);
      if (valid_o && r != 0) begin
         take_bits(stim_lfsr, 4, len);
         len = len + 1;
         lim = (valid_bytes_o > 16) ? 16 : int'(valid_bytes_o);
         if (len > lim) len = lim;
         ready_i      = 1'b1;
         bytes_read_i = read_cnt_t'(len);
      end else begin
         ready_i      = 1'b0;
         bytes_read_i = 5'd1;
      end
   endtask

   // Run random consumes until a count or an address is reached
   task automatic run_stream(input int target, input logic [31:0] stop_addr, input int max);
      int start, cyc;
      start = consumes;
      cyc   = 0;
      while (consumes < start + target || exp_addr < stop_addr) begin
         if (cyc >= max) check_cond(1'b0, "Timed out while streaming bytes to the decoder");
         drive_random_consume();
         @(negedge clk);
         cyc++;
      end
      ready_i = 1'b0;
   endtask

   initial begin
      int cyc;
      rst_i            = 1'b1;
      redirect_valid_i = 1'b0;
      redirect_addr_i  = '0;
      ready_i          = 1'b0;
      bytes_read_i     = 5'd1;
      stim_lfsr        = 16'd22;
      consumes         = 0;
      fault_seen       = 0;
      repeat (5) @(negedge clk);
      rst_i = 1'b0;
      @(negedge clk);
      check_cond(!arvalid_o && !rready_o && !valid_o && !fault_o, "Outputs active after reset");

      // Aligned stream
      do_redirect(32'h0000_1000);
      run_stream(60, 32'h0, 5000);

      // Unaligned start, one line present when valid_o rises
      do_redirect(32'h0000_2005);
      wait_for_valid(200);
      check_hex("valid_bytes_o", 128'(valid_bytes_o), 128'd11);
      check_hex("window_o byte 0", 128'(window_o[7:0]), 128'(mem_byte(32'h0000_2005)));
      run_stream(30, 32'h0, 3000);

      // Redirect while a read is outstanding, new target differs in its low address byte
      do_redirect(32'h0000_3000);
      cyc = 0;
      while (!rready_o) begin
         if (cyc >= 200) check_cond(1'b0, "Timed out waiting for an outstanding read");
         @(negedge clk);
         cyc++;
      end
      do_redirect(32'h0000_8080);
      wait_for_valid(300);
      check_hex("valid_bytes_o", 128'(valid_bytes_o), 128'd16);
      check_hex("window_o byte 0", 128'(window_o[7:0]), 128'(mem_byte(32'h0000_8080)));
      run_stream(30, 32'h0, 3000);

      // Back-pressure fills the ring
      do_redirect(32'h0000_4003);
      cyc = 0;
      while (valid_bytes_o != 7'd61) begin
         if (cyc >= 500) check_cond(1'b0, "Timed out waiting for the ring to fill");
         @(negedge clk);
         cyc++;
      end
      repeat (20) begin
         check_cond(!arvalid_o, "Read issued while all slots are full");
         check_hex("valid_bytes_o", 128'(valid_bytes_o), 128'd61);
         @(negedge clk);
      end
      ready_i      = 1'b1;
      bytes_read_i = 5'd13;
      @(negedge clk);
      ready_i = 1'b0;
      check_hex("valid_bytes_o", 128'(valid_bytes_o), 128'd48);
      cyc = 0;
      while (!arvalid_o) begin
         if (cyc >= 50) check_cond(1'b0, "Timed out waiting for a read after a slot was freed");
         @(negedge clk);
         cyc++;
      end
      run_stream(20, 32'h0, 3000);

      // Stream through the faulting line
      do_redirect(32'h0000_5000);
      run_stream(1, 32'h0000_5060, 5000);
      check_cond(fault_seen > 0, "fault_o never seen in the faulting line");

      // Long run with random latency
      do_redirect(32'h0000_6000);
      run_stream(400, 32'h0, 40000);

      $display("ALL CHECKS PASSED");
      $finish;
   end

endmodule

// File: files.f
iq_cfg_pkg.sv
axil_pkg.sv
iq_fetch_master.sv
iq_line_slot.sv
iq_byte_window.sv
instruction_queue_top.sv
iq_assert.sv
tb_instruction_queue.sv

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_instruction_queue \
   -f files.f -o sim_tb > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/sim_tb > sim.log 2>&1
cat sim.log
grep -q "CHECKS FAILED" sim.log && { echo "Simulation failed"; exit 1; }
grep -q "ALL CHECKS PASSED" sim.log || { echo "Simulation ended without a result"; exit 1; }
echo "Simulation passed"
exit 0
